// File: list.f
csr_types_pkg.sv
csr_map_pkg.sv
csr_issue_decode.sv
csr_reg_slot.sv
csr_writeback.sv
csr_unit.sv
csr_unit_tb.sv

// File: csr_unit_tb.sv
/* directed testbench for the CSR execution unit: a shadow model of the writable
   registers predicts every result, and each test task drives and checks the DUT */
`timescale 1ns/100ps

module csr_unit_tb;

	import csr_types_pkg::*;
	import csr_map_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam logic [XLEN-1:0] TB_HART_ID = 64'd3;
	localparam logic [31:0] TB_VENDOR_ID = 32'h0000_05A7;

	// random operations per run, each followed by a read back
	localparam int NUM_RANDOM = 48;

	// instructions in one back-to-back burst
	localparam int STREAM_LEN = 16;

	// cycles used by each test, a single operation takes two clocks
	localparam int TEST_CYCLES = RESET_CYCLES + 1 + 2 * NUM_SLOTS
		+ 2 * (5 * 4 + 3 * 2 + NUM_SLOTS)
		+ 4 * NUM_RANDOM
		+ 2 * 12
		+ 2 * 8
		+ 2 * (STREAM_LEN + 1);
	localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

	logic CLK;
	logic reset;
	logic be_flush;
	logic csr_exeparam_valid;
	csr_exeparam_t csr_exeparam;
	logic csr_writeback_valid;
	csr_result_t csr_result;

	// expected contents of every writable register
	logic [XLEN-1:0] shadow [NUM_SLOTS];

	csr_unit #(
		.HART_ID(TB_HART_ID),
		.VENDOR_ID(TB_VENDOR_ID)
	) csr_unit_i (
		.CLK(CLK),
		.reset(reset),
		.be_flush(be_flush),
		.csr_exeparam_valid(csr_exeparam_valid),
		.csr_exeparam(csr_exeparam),
		.csr_writeback_valid(csr_writeback_valid),
		.csr_result(csr_result)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_equal(input string name, input logic [XLEN-1:0] actual,
		input logic [XLEN-1:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
			stop_on_failure();
		end
	endtask

	// index of the slot that holds addr, or -1 for any other address
	function automatic int slot_of(input logic [11:0] addr);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (SLOT_ADDR[i] == addr) begin
				return i;
			end
		end
		return -1;
	endfunction

	// information registers, anything unknown reads zero
	function automatic logic [XLEN-1:0] readonly_value(input logic [11:0] addr);
		case (addr)
			CSR_MVENDORID: return {32'h0, TB_VENDOR_ID};
			CSR_MHARTID: return TB_HART_ID;
			CSR_MISA: return MISA_VALUE;
			default: return '0;
		endcase
	endfunction

	function automatic csr_fn_e random_fn();
		case ($urandom % 3)
			0: return csr_fn_rw;
			1: return csr_fn_rs;
			default: return csr_fn_rc;
		endcase
	endfunction

	// tags start at one so that rw always wants its old value
	function automatic rd_tag_t random_tag();
		return rd_tag_t'(($urandom % 127) + 1);
	endfunction

	// predicts valid and result of one instruction and applies its write to the shadow
	task automatic model_step(input csr_fn_e fn, input rd_tag_t rd0, input logic [XLEN-1:0] op,
		input logic [11:0] addr, input logic flush, output logic exp_valid,
		output logic [XLEN-1:0] exp_res);
		int idx;
		logic [XLEN-1:0] old_val;
		logic [XLEN-1:0] upd;
		idx = slot_of(addr);
		old_val = (idx >= 0) ? shadow[idx] : readonly_value(addr);
		exp_valid = ~flush;
		exp_res = (fn == csr_fn_rw && rd0 == '0) ? '0 : old_val;
		// rs and rc with a zero operand are plain reads
		if (!flush && idx >= 0 && !(fn != csr_fn_rw && op == '0)) begin
			case (fn)
				csr_fn_rw: upd = op;
				csr_fn_rs: upd = old_val | op;
				default: upd = old_val & ~op;
			endcase
			shadow[idx] = (upd & SLOT_WMASK[idx]) | (old_val & ~SLOT_WMASK[idx]);
		end
	endtask

	task automatic send(input csr_fn_e fn, input rd_tag_t rd0, input logic [XLEN-1:0] op,
		input logic [11:0] addr, input logic flush);
		csr_exeparam_t p;
		p.fn = fn;
		p.rd0 = rd0;
		p.op = op;
		p.addr = addr;
		@(posedge CLK);
		be_flush <= flush;
		csr_exeparam_valid <= 1'b1;
		csr_exeparam <= p;
	endtask

	task automatic send_idle();
		@(posedge CLK);
		be_flush <= 1'b0;
		csr_exeparam_valid <= 1'b0;
	endtask

	// sampled at the falling edge, half a clock after the result register loads
	task automatic check_result(input logic exp_valid, input rd_tag_t exp_tag,
		input logic [XLEN-1:0] exp_res);
		check_equal("csr_writeback_valid", csr_writeback_valid, exp_valid);
		if (exp_valid) begin
			check_equal("csr_result.rd0", csr_result.rd0, exp_tag);
			check_equal("csr_result.res", csr_result.res, exp_res);
		end
	endtask

	task automatic run_op(input csr_fn_e fn, input rd_tag_t rd0, input logic [XLEN-1:0] op,
		input logic [11:0] addr);
		logic ev;
		logic [XLEN-1:0] er;
		model_step(fn, rd0, op, addr, 1'b0, ev, er);
		send(fn, rd0, op, addr, 1'b0);
		send_idle();
		@(negedge CLK);
		check_result(ev, rd0, er);
	endtask

	task automatic read_all_slots();
		for (int i = 0; i < NUM_SLOTS; i++) begin
			run_op(csr_fn_rs, random_tag(), '0, SLOT_ADDR[i]);
		end
	endtask

	task automatic test_reset();
		repeat (RESET_CYCLES) @(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		check_equal("csr_writeback_valid", csr_writeback_valid, 1'b0);
		check_equal("csr_result.rd0", csr_result.rd0, '0);
		check_equal("csr_result.res", csr_result.res, '0);
		// shadow still holds the reset values here
		read_all_slots();
	endtask

	task automatic test_read_only();
		logic [11:0] ro_addr [5];
		logic [11:0] unknown_addr [3];
		ro_addr = '{CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MISA};
		// mscratch is not implemented in this unit, so it counts as unknown
		unknown_addr = '{12'h340, 12'h7C0, 12'hC00};
		for (int i = 0; i < 5; i++) begin
			run_op(csr_fn_rs, random_tag(), '0, ro_addr[i]);
			run_op(csr_fn_rw, random_tag(), {$urandom, $urandom}, ro_addr[i]);
			run_op(csr_fn_rs, random_tag(), '1, ro_addr[i]);
			run_op(csr_fn_rc, random_tag(), '0, ro_addr[i]);
		end
		for (int i = 0; i < 3; i++) begin
			run_op(csr_fn_rw, random_tag(), {$urandom, $urandom}, unknown_addr[i]);
			run_op(csr_fn_rs, random_tag(), '0, unknown_addr[i]);
		end
		// none of those writes may have reached a slot
		read_all_slots();
	endtask

	task automatic test_random_ops();
		logic [11:0] addr;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			addr = SLOT_ADDR[$urandom % NUM_SLOTS];
			run_op(random_fn(), random_tag(), {$urandom, $urandom}, addr);
			run_op(csr_fn_rs, random_tag(), '0, addr);
		end
	endtask

	task automatic test_suppression();
		// mepc gets a known nonzero value first so a leaked read would show
		run_op(csr_fn_rw, random_tag(), 64'h0000_0000_8000_0104, CSR_MEPC);
		// rw to x0 still writes but returns zero
		run_op(csr_fn_rw, '0, 64'h1234_5678_9ABC_DEF1, CSR_MEPC);
		run_op(csr_fn_rs, random_tag(), '0, CSR_MEPC);
		run_op(csr_fn_rw, random_tag(), '1, CSR_MIE);
		// zero operand turns rc and rs into reads of the current value
		run_op(csr_fn_rc, random_tag(), '0, CSR_MIE);
		run_op(csr_fn_rs, random_tag(), '0, CSR_MIE);
		run_op(csr_fn_rw, random_tag(), '0, CSR_MSTATUS);
		run_op(csr_fn_rs, random_tag(), '0, CSR_MSTATUS);
		run_op(csr_fn_rs, random_tag(), '0, CSR_MSTATUS);
		// x0 only silences rw, an rc into x0 must still return a nonzero mtvec
		run_op(csr_fn_rs, random_tag(), 64'h0000_0000_0000_0101, CSR_MTVEC);
		run_op(csr_fn_rc, '0, '0, CSR_MTVEC);
		run_op(csr_fn_rs, random_tag(), '0, CSR_MTVEC);
	endtask

	task automatic test_flush();
		logic ev_a;
		logic ev_b;
		logic [XLEN-1:0] er_a;
		logic [XLEN-1:0] er_b;
		rd_tag_t tag_a;
		// a flushed instruction gives no pulse and leaves mtval alone
		model_step(csr_fn_rw, 7'd9, '1, CSR_MTVAL, 1'b1, ev_b, er_b);
		send(csr_fn_rw, 7'd9, '1, CSR_MTVAL, 1'b1);
		send_idle();
		@(negedge CLK);
		check_result(ev_b, 7'd9, er_b);
		run_op(csr_fn_rs, random_tag(), '0, CSR_MTVAL);
		// an instruction accepted just before the flush still delivers its result
		tag_a = random_tag();
		model_step(csr_fn_rs, tag_a, 64'h55, CSR_MCAUSE, 1'b0, ev_a, er_a);
		model_step(csr_fn_rw, 7'd17, 64'hDEAD_BEEF, CSR_MCAUSE, 1'b1, ev_b, er_b);
		send(csr_fn_rs, tag_a, 64'h55, CSR_MCAUSE, 1'b0);
		send(csr_fn_rw, 7'd17, 64'hDEAD_BEEF, CSR_MCAUSE, 1'b1);
		@(negedge CLK);
		check_result(ev_a, tag_a, er_a);
		send_idle();
		@(negedge CLK);
		check_result(ev_b, 7'd17, er_b);
		run_op(csr_fn_rs, random_tag(), '0, CSR_MCAUSE);
	endtask

	// one instruction per clock, each result is checked while the next one is driven
	task automatic test_stream(input logic [11:0] addr);
		logic exp_v [STREAM_LEN];
		logic [XLEN-1:0] exp_r [STREAM_LEN];
		csr_fn_e fn;
		logic [XLEN-1:0] op;
		for (int i = 0; i <= STREAM_LEN; i++) begin
			if (i < STREAM_LEN) begin
				fn = random_fn();
				op = {$urandom, $urandom};
				model_step(fn, rd_tag_t'(i + 1), op, addr, 1'b0, exp_v[i], exp_r[i]);
				send(fn, rd_tag_t'(i + 1), op, addr, 1'b0);
			end else begin
				send_idle();
			end
			if (i > 0) begin
				@(negedge CLK);
				check_result(exp_v[i - 1], rd_tag_t'(i), exp_r[i - 1]);
			end
		end
	endtask

	// ends a run that stops making progress
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timed out after %0d ns, the tests did not finish", WATCHDOG_NS);
		stop_on_failure();
	end

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		be_flush = 1'b0;
		csr_exeparam_valid = 1'b0;
		csr_exeparam = '0;
		void'($urandom(32'h7ffc));
		for (int i = 0; i < NUM_SLOTS; i++) begin
			shadow[i] = SLOT_RESET[i];
		end
		test_reset();
		test_read_only();
		test_random_ops();
		test_suppression();
		test_flush();
		test_stream(CSR_MTVAL);
		test_stream(CSR_MSTATUS);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: csr_unit.sv
/* top of the machine-mode CSR execution unit: decoder, one slot per writable CSR
   built from the map tables, and the writeback register with one cycle of latency */
`timescale 1ns/100ps

module csr_unit #(
	parameter logic [csr_types_pkg::XLEN-1:0] HART_ID = '0,
	parameter logic [31:0] VENDOR_ID = 32'h0
) (
	input logic CLK,
	input logic reset,
	input logic be_flush,

	input logic csr_exeparam_valid,
	input csr_types_pkg::csr_exeparam_t csr_exeparam,

	output logic csr_writeback_valid,
	output csr_types_pkg::csr_result_t csr_result
);

	import csr_types_pkg::*;
	import csr_map_pkg::*;

	// request broadcast from decode to every slot
	csr_wr_req_t wr_req;

	// request from decode to writeback
	csr_rd_req_t rd_req;

	// per-slot read values, zero for every slot that is not addressed
	logic [XLEN-1:0] slot_rd_data [NUM_SLOTS];

	csr_issue_decode decode_i (
		.be_flush(be_flush),
		.csr_exeparam_valid(csr_exeparam_valid),
		.csr_exeparam(csr_exeparam),
		.wr_req(wr_req),
		.rd_req(rd_req)
	);

	// one slot per writable register, address, mask and reset value
	// come from the same index of the map tables
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		csr_reg_slot #(
			.SLOT_ADDR_P(SLOT_ADDR[i]),
			.WMASK(SLOT_WMASK[i]),
			.RESET_VAL(SLOT_RESET[i])
		) slot_i (
			.CLK(CLK),
			.reset(reset),
			.wr_req(wr_req),
			.rd_data(slot_rd_data[i])
		);
	end

	// hart and vendor ids are fixed per instance of the core
	csr_writeback #(
		.HART_ID(HART_ID),
		.VENDOR_ID(VENDOR_ID)
	) writeback_i (
		.CLK(CLK),
		.reset(reset),
		.rd_req(rd_req),
		.rd_data(slot_rd_data),
		.csr_writeback_valid(csr_writeback_valid),
		.csr_result(csr_result)
	);

endmodule

// File: csr_writeback.sv
/* result stage of the CSR unit: merges slot reads with the read-only information
   registers and registers the value, the destination tag and the valid pulse */
`timescale 1ns/100ps

module csr_writeback #(
	parameter logic [csr_types_pkg::XLEN-1:0] HART_ID = '0,
	parameter logic [31:0] VENDOR_ID = 32'h0
) (
	input logic CLK,
	input logic reset,
	input csr_types_pkg::csr_rd_req_t rd_req,
	input logic [csr_types_pkg::XLEN-1:0] rd_data [csr_map_pkg::NUM_SLOTS],

	output logic csr_writeback_valid,
	output csr_types_pkg::csr_result_t csr_result
);

	import csr_types_pkg::*;
	import csr_map_pkg::*;

	// OR of all slot outputs, at most one slot is addressed at a time
	logic [XLEN-1:0] slot_val;

	// value of the read-only register at rd_req.addr, zero if there is none
	logic [XLEN-1:0] ro_val;

	// value to be registered, zero when the read is suppressed
	logic [XLEN-1:0] res_dnxt;

	always_comb begin
		slot_val = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			slot_val = slot_val | rd_data[i];
		end
	end

	// mvendorid is 32 bits wide in the spec and reads zero-extended on RV64
	always_comb begin
		case (rd_req.addr)
			CSR_MVENDORID: ro_val = {{(XLEN-32){1'b0}}, VENDOR_ID};
			CSR_MARCHID: ro_val = MARCHID_VALUE;
			CSR_MIMPID: ro_val = MIMPID_VALUE;
			CSR_MHARTID: ro_val = HART_ID;
			CSR_MISA: ro_val = MISA_VALUE;
			default: ro_val = '0;
		endcase
	end

	// slot and read-only addresses never overlap, so a plain OR merges them
	// an unknown address matches neither and reads zero
	assign res_dnxt = rd_req.rd_en ? (slot_val | ro_val) : '0;

	// valid follows fire by exactly one clock
	// a later flush does not reach this register, so an accepted result is delivered
	always_ff @(posedge CLK) begin
		if (reset) begin
			csr_writeback_valid <= 1'b0;
		end else begin
			csr_writeback_valid <= rd_req.fire;
		end
	end

	// result and tag load only with an accepted instruction
	// between results the last one is held
	always_ff @(posedge CLK) begin
		if (reset) begin
			csr_result <= '0;
		end else if (rd_req.fire) begin
			csr_result.rd0 <= rd_req.rd0;
			csr_result.res <= res_dnxt;
		end
	end

endmodule

// File: csr_reg_slot.sv
/* one writable machine CSR: applies rw, rs or rc under its write mask when
   addressed, and drives its current value only while its address is selected */
`timescale 1ns/100ps

module csr_reg_slot #(
	parameter logic [11:0] SLOT_ADDR_P = 12'h000,
	parameter logic [csr_types_pkg::XLEN-1:0] WMASK = '1,
	parameter logic [csr_types_pkg::XLEN-1:0] RESET_VAL = '0
) (
	input logic CLK,
	input logic reset,
	input csr_types_pkg::csr_wr_req_t wr_req,

	output logic [csr_types_pkg::XLEN-1:0] rd_data
);

	import csr_types_pkg::*;

	// the architectural register itself
	logic [XLEN-1:0] csr_q;

	// value the operation would produce before masking
	logic [XLEN-1:0] csr_update;

	// masked next value, unwritable bits come from csr_q
	logic [XLEN-1:0] csr_dnxt;

	// this slot is the one addressed on the shared request bus
	logic hit;

	assign hit = (wr_req.addr == SLOT_ADDR_P);

	// rw replaces, rs sets the bits of op, rc clears them
	always_comb begin
		case (wr_req.fn)
			csr_fn_rw: csr_update = wr_req.op;
			csr_fn_rs: csr_update = csr_q | wr_req.op;
			csr_fn_rc: csr_update = csr_q & ~wr_req.op;
			default: csr_update = csr_q;
		endcase
	end

	assign csr_dnxt = (csr_update & WMASK) | (csr_q & ~WMASK);

	// en already carries fire and the op-zero rule from decode
	always_ff @(posedge CLK) begin
		if (reset) begin
			csr_q <= RESET_VAL;
		end else if (wr_req.en & hit) begin
			csr_q <= csr_dnxt;
		end
	end

	// zero when not addressed, so writeback can OR all slots together
	// the value read is the one before this cycle's write
	assign rd_data = hit ? csr_q : '0;

endmodule

// File: csr_issue_decode.sv
/* combinational front of the CSR unit: splits the execute parameter, applies flush
   and the read and write suppression rules, and forms the slot and writeback requests */
`timescale 1ns/100ps

module csr_issue_decode (
	input logic be_flush,
	input logic csr_exeparam_valid,
	input csr_types_pkg::csr_exeparam_t csr_exeparam,

	output csr_types_pkg::csr_wr_req_t wr_req,
	output csr_types_pkg::csr_rd_req_t rd_req
);

	import csr_types_pkg::*;

	// fields of the incoming instruction
	csr_fn_e fn;
	rd_tag_t rd0;
	logic [XLEN-1:0] op;
	logic [11:0] addr;

	// accepted this cycle and not discarded by the back end
	logic fire;

	// rw into x0 is a pure write, the old value is never needed
	logic dont_read;

	// rs or rc with a zero operand is a pure read and must not touch the register
	logic dont_write;

	// the operation class is needed for the write rule only
	logic is_set_clear;

	assign fn = csr_exeparam.fn;
	assign rd0 = csr_exeparam.rd0;
	assign op = csr_exeparam.op;
	assign addr = csr_exeparam.addr;

	// a flush in the same cycle kills the instruction outright
	// anything already registered in writeback is left alone
	assign fire = csr_exeparam_valid & ~be_flush;

	assign is_set_clear = (fn == csr_fn_rs) | (fn == csr_fn_rc);

	assign dont_read = (fn == csr_fn_rw) & (rd0 == '0);

	assign dont_write = is_set_clear & (op == '0);

	// write request goes to all slots at once
	// each slot decides on its own address whether it is the target
	always_comb begin
		wr_req.en = fire & ~dont_write;
		wr_req.fn = fn;
		wr_req.op = op;
		wr_req.addr = addr;
	end

	// read request to writeback
	// the slots put their value on rd_data from the same address,
	// so writeback sees the value from before this cycle's write
	always_comb begin
		rd_req.fire = fire;
		rd_req.rd_en = fire & ~dont_read;
		rd_req.addr = addr;
		rd_req.rd0 = rd0;
	end

	// illegal encodings and writes to read-only or unknown addresses
	// raise no exception here, they simply find no slot that matches

endmodule

// File: csr_map_pkg.sv
/* machine CSR address map, the per-slot masks and reset values of the writable
   registers, and the fixed values of the read-only information registers */
package csr_map_pkg;

	// machine trap setup
	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MISA = 12'h301;
	localparam logic [11:0] CSR_MIE = 12'h304;
	localparam logic [11:0] CSR_MTVEC = 12'h305;

	// machine trap handling
	localparam logic [11:0] CSR_MEPC = 12'h341;
	localparam logic [11:0] CSR_MCAUSE = 12'h342;
	localparam logic [11:0] CSR_MTVAL = 12'h343;
	localparam logic [11:0] CSR_MIP = 12'h344;

	// machine information registers, all read-only
	localparam logic [11:0] CSR_MVENDORID = 12'hF11;
	localparam logic [11:0] CSR_MARCHID = 12'hF12;
	localparam logic [11:0] CSR_MIMPID = 12'hF13;
	localparam logic [11:0] CSR_MHARTID = 12'hF14;

	// number of writable registers, each one a csr_reg_slot instance
	localparam int NUM_SLOTS = 7;

	// slot order is mstatus, mie, mtvec, mepc, mcause, mtval, mip
	localparam logic [11:0] SLOT_ADDR [NUM_SLOTS] = '{
		CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP
	};

	// writable bits per slot, a cleared bit keeps its current value on every write
	// mstatus exposes MIE (3), MPIE (7) and MPP (12:11)
	// mie exposes the machine software, timer and external enables
	// mtvec bit 1 is reserved in the mode field, mepc bit 0 is always zero
	// mip lets software touch only MSIP and MTIP, MEIP comes from the interrupt controller
	localparam logic [csr_types_pkg::XLEN-1:0] SLOT_WMASK [NUM_SLOTS] = '{
		64'h0000_0000_0000_1888,
		64'h0000_0000_0000_0888,
		64'hFFFF_FFFF_FFFF_FFFD,
		64'hFFFF_FFFF_FFFF_FFFE,
		64'hFFFF_FFFF_FFFF_FFFF,
		64'hFFFF_FFFF_FFFF_FFFF,
		64'h0000_0000_0000_0088
	};

	// values loaded by reset, mstatus starts with MPP set to machine mode
	localparam logic [csr_types_pkg::XLEN-1:0] SLOT_RESET [NUM_SLOTS] = '{
		64'h0000_0000_0000_1800,
		64'h0000_0000_0000_0000,
		64'h0000_0000_0000_0000,
		64'h0000_0000_0000_0000,
		64'h0000_0000_0000_0000,
		64'h0000_0000_0000_0000,
		64'h0000_0000_0000_0000
	};

	// misa reports MXL = 2 (64-bit) and only the base integer extension, bit 8
	localparam logic [csr_types_pkg::XLEN-1:0] MISA_VALUE = 64'h8000_0000_0000_0100;

	// no architecture or implementation id is registered for this core
	localparam logic [csr_types_pkg::XLEN-1:0] MARCHID_VALUE = '0;
	localparam logic [csr_types_pkg::XLEN-1:0] MIMPID_VALUE = '0;

endpackage

// File: csr_types_pkg.sv
/* shared types for the CSR execution unit: operation encodings and the structs
   passed from issue to the register slots and on to writeback */
package csr_types_pkg;

	// architectural register width of the RV64 core
	localparam int XLEN = 64;

	// rename bits appended to the 5-bit architectural register index
	localparam int RNBIT = 2;

	// CSR operation as decoded by the front end
	// zero is left unused so an idle bus never looks like a write
	typedef enum logic [1:0] {
		csr_fn_rw = 2'd1,
		csr_fn_rs = 2'd2,
		csr_fn_rc = 2'd3
	} csr_fn_e;

	// physical destination tag, architectural index plus rename bits
	typedef logic [5+RNBIT-1:0] rd_tag_t;

	// instruction as delivered by the issue queue
	// op is the rs1 value or the zero-extended immediate, already selected upstream
	typedef struct packed {
		csr_fn_e fn;
		rd_tag_t rd0;
		logic [XLEN-1:0] op;
		logic [11:0] addr;
	} csr_exeparam_t;

	// write request broadcast to every register slot
	// en already folds in flush and the op-zero rule for rs and rc,
	// so a slot only needs to check its own address
	typedef struct packed {
		logic en;
		csr_fn_e fn;
		logic [XLEN-1:0] op;
		logic [11:0] addr;
	} csr_wr_req_t;

	// read request handed to writeback
	// fire means an instruction was accepted this cycle and will produce a result
	// rd_en is low when the old value is not wanted (rw to x0)
	typedef struct packed {
		logic fire;
		logic rd_en;
		logic [11:0] addr;
		rd_tag_t rd0;
	} csr_rd_req_t;

	// registered result returned to the rename and commit logic
	typedef struct packed {
		rd_tag_t rd0;
		logic [XLEN-1:0] res;
	} csr_result_t;

endpackage
